/* rtl/rvPkg.sv */
// shared widths, opcodes, alu codes, control bit indices and instruction views of the rv32i core
package rvPkg;

  localparam int xlen = 32;
  localparam int regIdxWidth = 5;
  localparam int aluOpWidth = 4;
  localparam int accessWidth = 2;
  localparam int ctrlWidth = 11;

  // major opcodes
  localparam logic [6:0] opLui = 7'b0110111;
  localparam logic [6:0] opAuipc = 7'b0010111;
  localparam logic [6:0] opJal = 7'b1101111;
  localparam logic [6:0] opJalr = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opReg = 7'b0110011;
  localparam logic [6:0] opSystem = 7'b1110011;

  localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
  localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
  localparam logic [aluOpWidth-1:0] aluSll = 4'd2;
  localparam logic [aluOpWidth-1:0] aluSlt = 4'd3;
  localparam logic [aluOpWidth-1:0] aluSltu = 4'd4;
  localparam logic [aluOpWidth-1:0] aluXor = 4'd5;
  localparam logic [aluOpWidth-1:0] aluSrl = 4'd6;
  localparam logic [aluOpWidth-1:0] aluSra = 4'd7;
  localparam logic [aluOpWidth-1:0] aluOr = 4'd8;
  localparam logic [aluOpWidth-1:0] aluAnd = 4'd9;
  localparam logic [aluOpWidth-1:0] aluPassB = 4'd10;
  localparam logic [aluOpWidth-1:0] aluEq = 4'd11;
  localparam logic [aluOpWidth-1:0] aluNe = 4'd12;
  localparam logic [aluOpWidth-1:0] aluGe = 4'd13;
  localparam logic [aluOpWidth-1:0] aluGeu = 4'd14;
  // blt and bltu give the same 1/0 as slt and sltu
  localparam logic [aluOpWidth-1:0] aluLt = aluSlt;
  localparam logic [aluOpWidth-1:0] aluLtu = aluSltu;

  // same encoding as funct3[1:0] of loads and stores
  localparam logic [accessWidth-1:0] sizeByte = 2'd0;
  localparam logic [accessWidth-1:0] sizeHalf = 2'd1;
  localparam logic [accessWidth-1:0] sizeWord = 2'd2;

  localparam int ctrlRegWen = 0;
  localparam int ctrlMemWen = 1;
  localparam int ctrlIsLoad = 2;
  localparam int ctrlIsBranch = 3;
  localparam int ctrlIsJal = 4;
  localparam int ctrlIsJalr = 5;
  localparam int ctrlUsePc = 6;
  localparam int ctrlNeedImm = 7;
  localparam int ctrlUnsigned = 8;
  localparam int ctrlEbreak = 9;
  localparam int ctrlIllegal = 10;

  // addi x0,x0,0
  localparam logic [xlen-1:0] nopWord = 32'h0000_0013;

  typedef struct packed {
    logic [6:0] funct7;
    logic [regIdxWidth-1:0] rs2;
    logic [regIdxWidth-1:0] rs1;
    logic [2:0] funct3;
    logic [regIdxWidth-1:0] rd;
    logic [6:0] opcode;
  } rFields;

  typedef struct packed {
    logic [11:0] imm;
    logic [regIdxWidth-1:0] rs1;
    logic [2:0] funct3;
    logic [regIdxWidth-1:0] rd;
    logic [6:0] opcode;
  } iFields;

  typedef struct packed {
    logic [6:0] immHi;
    logic [regIdxWidth-1:0] rs2;
    logic [regIdxWidth-1:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sFields;

  typedef struct packed {
    logic imm12;
    logic [5:0] imm10To5;
    logic [regIdxWidth-1:0] rs2;
    logic [regIdxWidth-1:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4To1;
    logic imm11;
    logic [6:0] opcode;
  } bFields;

  typedef struct packed {
    logic [19:0] imm;
    logic [regIdxWidth-1:0] rd;
    logic [6:0] opcode;
  } uFields;

  typedef struct packed {
    logic imm20;
    logic [9:0] imm10To1;
    logic imm11;
    logic [7:0] imm19To12;
    logic [regIdxWidth-1:0] rd;
    logic [6:0] opcode;
  } jFields;

  // one instruction word seen in each of the six formats
  typedef union packed {
    rFields rType;
    iFields iType;
    sFields sType;
    bFields bType;
    uFields uType;
    jFields jType;
  } instWord;

endpackage

/* rtl/decodeIf.sv */
// decoded fields of the id-stage instruction, driven by the decoder and read by the core top
`timescale 1ns/1ps

interface decodeIf;
  import rvPkg::*;

  logic [regIdxWidth-1:0] rs1;
  logic [regIdxWidth-1:0] rs2;
  logic [regIdxWidth-1:0] rd;
  logic [xlen-1:0] imm;
  logic [aluOpWidth-1:0] aluOp;
  logic [accessWidth-1:0] size;
  logic [ctrlWidth-1:0] ctrl;

  // decoder side
  modport producer (
    output rs1, rs2, rd, imm, aluOp, size, ctrl
  );

  // id/ex register and forwarding side
  modport consumer (
    input rs1, rs2, rd, imm, aluOp, size, ctrl
  );

endinterface

/* rtl/instRom.sv */
// program memory, read combinationally at the fetch address and loaded through a write port
`timescale 1ns/1ps

module instRom #(
  parameter int instDepth = 256,
  localparam int addrWidth = $clog2(instDepth)
) (
  input  logic clk,
  input  logic [addrWidth-1:0] addr,
  output logic [rvPkg::xlen-1:0] inst,
  input  logic we,
  input  logic [addrWidth-1:0] waddr,
  input  logic [rvPkg::xlen-1:0] wdata
);
  import rvPkg::*;

  logic [xlen-1:0] mem [instDepth];

  // program load, one word per edge
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign inst = mem[addr];

endmodule

/* rtl/decoder.sv */
// id-stage decoder, turns an instruction word into operands, immediate, alu code and control bits
`timescale 1ns/1ps

module decoder (
  input rvPkg::instWord inst,
  decodeIf.producer dec
);
  import rvPkg::*;

  localparam logic [xlen-1:0] ebreakWord = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] iImm;
  logic [xlen-1:0] sImm;
  logic [xlen-1:0] bImm;
  logic [xlen-1:0] uImm;
  logic [xlen-1:0] jImm;
  logic bad;

  // opcode and funct fields sit at the same bits in every format
  assign opcode = inst.rType.opcode;
  assign funct3 = inst.rType.funct3;
  assign funct7 = inst.rType.funct7;

  assign iImm = {{20{inst.iType.imm[11]}}, inst.iType.imm};
  assign sImm = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
  assign bImm = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                 inst.bType.imm10To5, inst.bType.imm4To1, 1'b0};
  assign uImm = {inst.uType.imm, 12'b0};
  assign jImm = {{11{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19To12,
                 inst.jType.imm11, inst.jType.imm10To1, 1'b0};

  always_comb begin
    dec.rs1 = inst.rType.rs1;
    dec.rs2 = inst.rType.rs2;
    dec.rd = inst.rType.rd;
    dec.imm = '0;
    dec.aluOp = aluAdd;
    dec.size = sizeWord;
    dec.ctrl = '0;
    bad = 1'b0;
    case (opcode)
      opLui, opAuipc: begin
        dec.rs1 = '0;
        dec.rs2 = '0;
        dec.imm = uImm;
        dec.aluOp = (opcode == opLui) ? aluPassB : aluAdd;
        dec.ctrl[ctrlUsePc] = (opcode == opAuipc);
        dec.ctrl[ctrlRegWen] = 1'b1;
        dec.ctrl[ctrlNeedImm] = 1'b1;
      end
      opJal: begin
        dec.rs1 = '0;
        dec.rs2 = '0;
        dec.imm = jImm;
        dec.ctrl[ctrlRegWen] = 1'b1;
        dec.ctrl[ctrlIsJal] = 1'b1;
        dec.ctrl[ctrlUsePc] = 1'b1;
        dec.ctrl[ctrlNeedImm] = 1'b1;
      end
      opJalr: begin
        dec.rs2 = '0;
        dec.imm = iImm;
        dec.ctrl[ctrlRegWen] = 1'b1;
        dec.ctrl[ctrlIsJalr] = 1'b1;
        dec.ctrl[ctrlNeedImm] = 1'b1;
        bad = (funct3 != 3'b000);
      end
      opBranch: begin
        dec.rd = '0;
        dec.imm = bImm;
        dec.ctrl[ctrlIsBranch] = 1'b1;
        case (funct3)
          3'b000: dec.aluOp = aluEq;
          3'b001: dec.aluOp = aluNe;
          3'b100: dec.aluOp = aluLt;
          3'b101: dec.aluOp = aluGe;
          3'b110: dec.aluOp = aluLtu;
          3'b111: dec.aluOp = aluGeu;
          default: bad = 1'b1;
        endcase
      end
      opLoad: begin
        dec.rs2 = '0;
        dec.imm = iImm;
        dec.size = funct3[1:0];
        dec.ctrl[ctrlRegWen] = 1'b1;
        dec.ctrl[ctrlIsLoad] = 1'b1;
        dec.ctrl[ctrlNeedImm] = 1'b1;
        dec.ctrl[ctrlUnsigned] = funct3[2];
        // lbu and lhu only, no unsigned word on rv32
        bad = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      opStore: begin
        dec.rd = '0;
        dec.imm = sImm;
        dec.size = funct3[1:0];
        dec.ctrl[ctrlMemWen] = 1'b1;
        dec.ctrl[ctrlNeedImm] = 1'b1;
        bad = funct3[2] || (funct3[1:0] == 2'b11);
      end
      opImm, opReg: begin
        if (opcode == opImm) begin
          dec.rs2 = '0;
          dec.imm = iImm;
          dec.ctrl[ctrlNeedImm] = 1'b1;
        end
        dec.ctrl[ctrlRegWen] = 1'b1;
        case (funct3)
          3'b000: dec.aluOp = (opcode == opReg && funct7[5]) ? aluSub : aluAdd;
          3'b001: dec.aluOp = aluSll;
          3'b010: dec.aluOp = aluSlt;
          3'b011: dec.aluOp = aluSltu;
          3'b100: dec.aluOp = aluXor;
          3'b101: dec.aluOp = funct7[5] ? aluSra : aluSrl;
          3'b110: dec.aluOp = aluOr;
          default: dec.aluOp = aluAnd;
        endcase
        // funct7 is immediate bits for addi-style ops, checked only for shifts and reg ops
        if (opcode == opReg || funct3 == 3'b001 || funct3 == 3'b101) begin
          bad = !(funct7 == 7'b0000000 ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                                            (funct3 == 3'b000 && opcode == opReg))));
        end
      end
      opSystem: begin
        if (inst == ebreakWord) begin
          dec.ctrl[ctrlEbreak] = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
    // an illegal word must not touch registers, memory or the pc
    if (bad) begin
      dec.ctrl = '0;
      dec.ctrl[ctrlIllegal] = 1'b1;
    end
  end

endmodule

/* rtl/regFile.sv */
// integer register file with two asynchronous read ports and one write port, x0 reads as zero
`timescale 1ns/1ps

module regFile (
  input  logic clk,
  input  logic [rvPkg::regIdxWidth-1:0] rs1,
  input  logic [rvPkg::regIdxWidth-1:0] rs2,
  output logic [rvPkg::xlen-1:0] rdata1,
  output logic [rvPkg::xlen-1:0] rdata2,
  input  logic wen,
  input  logic [rvPkg::regIdxWidth-1:0] rd,
  input  logic [rvPkg::xlen-1:0] wdata
);
  import rvPkg::*;

  logic [xlen-1:0] regs [2**regIdxWidth];

  always_ff @(posedge clk) begin
    if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is never written, so force its read value
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rtl/alu.sv */
// execute-stage alu for arithmetic, logic, shifts, set-less-than and branch conditions
`timescale 1ns/1ps

module alu (
  input  logic [rvPkg::xlen-1:0] opA,
  input  logic [rvPkg::xlen-1:0] opB,
  input  logic [rvPkg::aluOpWidth-1:0] aluOp,
  output logic [rvPkg::xlen-1:0] result
);
  import rvPkg::*;

  logic [4:0] shamt;
  logic lessSigned;
  logic lessUnsigned;
  logic equal;

  assign shamt = opB[4:0];
  assign lessSigned = ($signed(opA) < $signed(opB));
  assign lessUnsigned = (opA < opB);
  assign equal = (opA == opB);

  always_comb begin
    case (aluOp)
      aluAdd: result = opA + opB;
      aluSub: result = opA - opB;
      aluSll: result = opA << shamt;
      aluXor: result = opA ^ opB;
      aluSrl: result = opA >> shamt;
      aluSra: result = $signed(opA) >>> shamt;
      aluOr: result = opA | opB;
      aluAnd: result = opA & opB;
      aluPassB: result = opB;
      // compares give 0 or 1
      aluSlt: result = {{(xlen - 1){1'b0}}, lessSigned};
      aluSltu: result = {{(xlen - 1){1'b0}}, lessUnsigned};
      aluEq: result = {{(xlen - 1){1'b0}}, equal};
      aluNe: result = {{(xlen - 1){1'b0}}, !equal};
      aluGe: result = {{(xlen - 1){1'b0}}, !lessSigned};
      aluGeu: result = {{(xlen - 1){1'b0}}, !lessUnsigned};
      default: result = '0;
    endcase
  end

endmodule

/* rtl/dataMem.sv */
// byte-addressed data memory with sized stores and sign or zero extended loads
`timescale 1ns/1ps

module dataMem #(
  parameter int dataDepth = 256,
  localparam int wordAddrWidth = $clog2(dataDepth)
) (
  input  logic clk,
  input  logic [rvPkg::xlen-1:0] addr,
  input  logic [rvPkg::xlen-1:0] wdata,
  input  logic wen,
  input  logic [rvPkg::accessWidth-1:0] size,
  input  logic isUnsigned,
  output logic [rvPkg::xlen-1:0] rdata
);
  import rvPkg::*;

  logic [xlen-1:0] mem [dataDepth];
  logic [wordAddrWidth-1:0] wordIdx;
  logic [1:0] byteOff;
  logic [3:0] byteEn;
  logic [xlen-1:0] wdataLane;
  logic [xlen-1:0] shifted;

  assign wordIdx = addr[2 +: wordAddrWidth];
  assign byteOff = addr[1:0];

  // move store data onto the addressed byte lanes
  assign wdataLane = wdata << {byteOff, 3'b000};

  always_comb begin
    case (size)
      sizeByte: byteEn = 4'b0001 << byteOff;
      sizeHalf: byteEn = 4'b0011 << byteOff;
      default: byteEn = 4'b1111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      for (int i = 0; i < 4; i++) begin
        if (byteEn[i]) begin
          mem[wordIdx][8*i +: 8] <= wdataLane[8*i +: 8];
        end
      end
    end
  end

  // selected byte or half lands in the low bits
  assign shifted = mem[wordIdx] >> {byteOff, 3'b000};

  always_comb begin
    case (size)
      sizeByte: rdata = isUnsigned ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
      sizeHalf: rdata = isUnsigned ? {16'b0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
      default: rdata = shifted;
    endcase
  end

endmodule

/* rtl/cpu.sv */
// three-stage rv32i core top, fetch, decode with forwarding, and execute with memory and writeback
`timescale 1ns/1ps

module cpu #(
  parameter int instDepth = 256,
  parameter int dataDepth = 256,
  localparam int progAddrWidth = $clog2(instDepth)
) (
  input  logic clk,
  input  logic rstN,
  input  logic run,
  input  logic progWe,
  input  logic [progAddrWidth-1:0] progAddr,
  input  logic [rvPkg::xlen-1:0] progData,
  output logic [rvPkg::xlen-1:0] pc,
  output logic wbEn,
  output logic [rvPkg::regIdxWidth-1:0] wbRd,
  output logic [rvPkg::xlen-1:0] wbData,
  output logic halted,
  output logic illegal
);
  import rvPkg::*;

  logic [xlen-1:0] fetchWord;
  logic [xlen-1:0] idPc;
  instWord idInst;
  logic [xlen-1:0] rfData1;
  logic [xlen-1:0] rfData2;
  logic [xlen-1:0] idOp1;
  logic [xlen-1:0] idOp2;

  logic [xlen-1:0] exPc;
  logic [xlen-1:0] exRs1Val;
  logic [xlen-1:0] exRs2Val;
  logic [xlen-1:0] exImm;
  logic [aluOpWidth-1:0] exAluOp;
  logic [accessWidth-1:0] exSize;
  logic [ctrlWidth-1:0] exCtrl;
  logic [regIdxWidth-1:0] exRd;

  logic [xlen-1:0] opA;
  logic [xlen-1:0] opB;
  logic [xlen-1:0] aluResult;
  logic [xlen-1:0] loadData;
  logic [xlen-1:0] target;
  logic isJump;
  logic redirect;

  decodeIf decBus ();

  instRom #(.instDepth(instDepth)) uInstRom (
    .clk(clk),
    .addr(pc[2 +: progAddrWidth]),
    .inst(fetchWord),
    .we(progWe),
    .waddr(progAddr),
    .wdata(progData)
  );

  // IF/ID, bubbles on redirect, stall or halt
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idInst <= nopWord;
    end else if (redirect || !run || halted) begin
      idInst <= nopWord;
    end else begin
      idInst <= fetchWord;
    end
  end

  always_ff @(posedge clk) begin
    idPc <= pc;
  end

  decoder uDecoder (
    .inst(idInst),
    .dec(decBus)
  );

  regFile uRegFile (
    .clk(clk),
    .rs1(decBus.rs1),
    .rs2(decBus.rs2),
    .rdata1(rfData1),
    .rdata2(rfData2),
    .wen(wbEn),
    .rd(exRd),
    .wdata(wbData)
  );

  // ex result bypasses the register file write that lands at the end of this cycle
  assign idOp1 = (wbEn && exRd == decBus.rs1) ? wbData : rfData1;
  assign idOp2 = (wbEn && exRd == decBus.rs2) ? wbData : rfData2;

  // ID/EX control part
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exCtrl <= '0;
      exRd <= '0;
    end else if (redirect) begin
      exCtrl <= '0;
      exRd <= '0;
    end else begin
      exCtrl <= decBus.ctrl;
      exRd <= decBus.rd;
    end
  end

  always_ff @(posedge clk) begin
    exPc <= idPc;
    exRs1Val <= idOp1;
    exRs2Val <= idOp2;
    exImm <= decBus.imm;
    exAluOp <= decBus.aluOp;
    exSize <= decBus.size;
  end

  assign opA = exCtrl[ctrlUsePc] ? exPc : exRs1Val;
  assign opB = exCtrl[ctrlNeedImm] ? exImm : exRs2Val;

  alu uAlu (
    .opA(opA),
    .opB(opB),
    .aluOp(exAluOp),
    .result(aluResult)
  );

  dataMem #(.dataDepth(dataDepth)) uDataMem (
    .clk(clk),
    .addr(aluResult),
    .wdata(exRs2Val),
    .wen(exCtrl[ctrlMemWen]),
    .size(exSize),
    .isUnsigned(exCtrl[ctrlUnsigned]),
    .rdata(loadData)
  );

  assign isJump = exCtrl[ctrlIsJal] || exCtrl[ctrlIsJalr];
  assign wbEn = exCtrl[ctrlRegWen] && (exRd != '0);
  assign wbRd = exRd;
  assign wbData = isJump ? (exPc + xlen'(4)) :
                  exCtrl[ctrlIsLoad] ? loadData : aluResult;

  // taken branch or any jump kills the two younger slots
  assign redirect = (exCtrl[ctrlIsBranch] && aluResult[0]) || isJump;
  assign target = exCtrl[ctrlIsJalr] ? {aluResult[xlen-1:1], 1'b0} : (exPc + exImm);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= target;
    end else if (run && !halted) begin
      pc <= pc + xlen'(4);
    end
  end

  // halted covers both stop causes, illegal tells them apart
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      halted <= 1'b0;
      illegal <= 1'b0;
    end else begin
      if (exCtrl[ctrlEbreak] || exCtrl[ctrlIllegal]) begin
        halted <= 1'b1;
      end
      if (exCtrl[ctrlIllegal]) begin
        illegal <= 1'b1;
      end
    end
  end

endmodule

/* bench/cpuTbProg.svh */
// directed programs and their expected writeback trace, included into the core testbench
localparam int progCount = 2;

// each run's slice of progWords and expTrace and whether it ends on an illegal word
int progStart [progCount] = '{0, 51};
int progLen [progCount] = '{51, 4};
int traceStart [progCount] = '{0, 30};
int traceLen [progCount] = '{30, 1};
logic expIllegal [progCount] = '{1'b0, 1'b1};

logic [31:0] progWords [55] = '{
  32'h0050_0093, // 00 addi x1, x0, 5
  32'hffd0_0113, // 04 addi x2, x0, -3
  32'h0020_81b3, // 08 add x3, x1, x2
  32'h4020_8233, // 0c sub x4, x1, x2
  32'h1234_52b7, // 10 lui x5, 0x12345
  32'h0000_1317, // 14 auipc x6, 0x1
  32'h0070_8013, // 18 addi x0, x1, 7
  32'h00f1_4393, // 1c xori x7, x2, 15
  32'h0030_9413, // 20 slli x8, x1, 3
  32'h4011_5493, // 24 srai x9, x2, 1
  32'h01c1_5513, // 28 srli x10, x2, 28
  32'h0011_25b3, // 2c slt x11, x2, x1
  32'h0011_3633, // 30 sltu x12, x2, x1
  32'h0083_e6b3, // 34 or x13, x7, x8
  32'h1000_0793, // 38 addi x15, x0, 256
  32'h8765_4837, // 3c lui x16, 0x87654
  32'h3218_0813, // 40 addi x16, x16, 0x321
  32'h0107_a023, // 44 sw x16, 0(x15)
  32'h0107_a223, // 48 sw x16, 4(x15)
  32'h0027_82a3, // 4c sb x2, 5(x15)
  32'h0077_9323, // 50 sh x7, 6(x15)
  32'h0007_8883, // 54 lb x17, 0(x15)
  32'h0037_8903, // 58 lb x18, 3(x15)
  32'h0037_c983, // 5c lbu x19, 3(x15)
  32'h0027_9a03, // 60 lh x20, 2(x15)
  32'h0027_da83, // 64 lhu x21, 2(x15)
  32'h0047_ab03, // 68 lw x22, 4(x15)
  32'h001b_0c13, // 6c addi x24, x22, 1
  32'h0010_8663, // 70 beq x1, x1, +12
  32'h0630_0c93, // 74 addi x25, x0, 99
  32'h0630_0c93, // 78 addi x25, x0, 99
  32'h0010_9463, // 7c bne x1, x1, +8
  32'h0010_0c93, // 80 addi x25, x0, 1
  32'h0011_4663, // 84 blt x2, x1, +12
  32'h0630_0c93, // 88 addi x25, x0, 99
  32'h0630_0c93, // 8c addi x25, x0, 99
  32'h0020_f463, // 90 bgeu x1, x2, +8
  32'h002c_8c93, // 94 addi x25, x25, 2
  32'h00c0_0d6f, // 98 jal x26, +12
  32'h0630_0c93, // 9c addi x25, x0, 99
  32'h0630_0c93, // a0 addi x25, x0, 99
  32'h0000_0e17, // a4 auipc x28, 0
  32'h011e_0e13, // a8 addi x28, x28, 17
  32'h008e_0de7, // ac jalr x27, 8(x28)
  32'h0630_0c93, // b0 addi x25, x0, 99
  32'h0630_0c93, // b4 addi x25, x0, 99
  32'h0630_0c93, // b8 addi x25, x0, 99
  32'h000d_8e93, // bc addi x29, x27, 0
  32'h0010_0073, // c0 ebreak
  32'h0000_0013, // c4 nop
  32'h0000_0013, // c8 nop
  // second run
  32'h0070_0093, // 00 addi x1, x0, 7
  32'hffff_ffff, // 04 undefined opcode
  32'h0000_0013, // 08 nop
  32'h0000_0013  // 0c nop
};

// rd in bits 36:32, value in bits 31:0
logic [36:0] expTrace [31] = '{
  {5'd1, 32'h0000_0005},
  {5'd2, 32'hffff_fffd},
  {5'd3, 32'h0000_0002},
  {5'd4, 32'h0000_0008},
  {5'd5, 32'h1234_5000},
  {5'd6, 32'h0000_1014},
  {5'd7, 32'hffff_fff2},
  {5'd8, 32'h0000_0028},
  {5'd9, 32'hffff_fffe},
  {5'd10, 32'h0000_000f},
  {5'd11, 32'h0000_0001},
  {5'd12, 32'h0000_0000},
  {5'd13, 32'hffff_fffa},
  {5'd15, 32'h0000_0100},
  {5'd16, 32'h8765_4000},
  {5'd16, 32'h8765_4321},
  {5'd17, 32'h0000_0021},
  {5'd18, 32'hffff_ff87},
  {5'd19, 32'h0000_0087},
  {5'd20, 32'hffff_8765},
  {5'd21, 32'h0000_8765},
  {5'd22, 32'hfff2_fd21},
  {5'd24, 32'hfff2_fd22},
  {5'd25, 32'h0000_0001},
  {5'd25, 32'h0000_0003},
  {5'd26, 32'h0000_009c},
  {5'd28, 32'h0000_00a4},
  {5'd28, 32'h0000_00b5},
  {5'd27, 32'h0000_00b0},
  {5'd29, 32'h0000_00b0},
  {5'd1, 32'h0000_0007}
};

/* bench/cpuTb.sv */
// testbench for the rv32i core, runs each directed program with random gaps and checks the trace
`timescale 1ns/1ps

module cpuTb;
  import rvPkg::*;

  localparam int instDepth = 256;
  localparam int dataDepth = 256;
  localparam int progAddrWidth = $clog2(instDepth);
  localparam int haltTimeout = 2000;

  `include "cpuTbProg.svh"

  logic clk = 1'b0;
  logic rstN;
  logic run;
  logic progWe;
  logic [progAddrWidth-1:0] progAddr;
  logic [xlen-1:0] progData;
  logic [xlen-1:0] pc;
  logic wbEn;
  logic [regIdxWidth-1:0] wbRd;
  logic [xlen-1:0] wbData;
  logic halted;
  logic illegal;

  integer seed;
  logic tracing;
  int traceIdx;
  int traceEnd;

  cpu #(.instDepth(instDepth), .dataDepth(dataDepth)) dut (
    .clk(clk),
    .rstN(rstN),
    .run(run),
    .progWe(progWe),
    .progAddr(progAddr),
    .progData(progData),
    .pc(pc),
    .wbEn(wbEn),
    .wbRd(wbRd),
    .wbData(wbData),
    .halted(halted),
    .illegal(illegal)
  );

  always #5 clk = ~clk;

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input logic [xlen-1:0] actual,
                           input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                $time, name, actual, expected));
    end
  endtask

  task automatic checkReg(input string name, input logic [regIdxWidth-1:0] actual,
                          input logic [regIdxWidth-1:0] expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch at %0t ns: %s got x%0d expected x%0d",
                                $time, name, actual, expected));
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                $time, name, actual, expected));
    end
  endtask

  // writeback values are those of the ex cycle ending at this edge
  always @(posedge clk) begin
    if (tracing && wbEn === 1'b1) begin
      if (traceIdx >= traceEnd) begin
        stopWithFailure($sformatf("unexpected extra writeback to x%0d at %0t ns", wbRd, $time));
      end else begin
        checkReg("wbRd", wbRd, expTrace[traceIdx][36:32]);
        checkWord("wbData", wbData, expTrace[traceIdx][31:0]);
        traceIdx++;
      end
    end
  end

  // one word per falling edge while run is low
  task automatic loadProgram(input int first, input int count);
    for (int i = 0; i < count; i++) begin
      progWe = 1'b1;
      progAddr = progAddrWidth'(i);
      progData = progWords[first + i];
      @(negedge clk);
    end
    progWe = 1'b0;
  endtask

  task automatic runProgram(input int p);
    int cycles;
    @(negedge clk);
    rstN = 1'b0;
    run = 1'b0;
    tracing = 1'b0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;
    checkFlag("halted", halted, 1'b0);
    checkFlag("illegal", illegal, 1'b0);
    checkFlag("wbEn", wbEn, 1'b0);
    loadProgram(progStart[p], progLen[p]);
    // pc stays at the reset address while run is low
    checkWord("pc", pc, '0);
    traceIdx = traceStart[p];
    traceEnd = traceStart[p] + traceLen[p];
    tracing = 1'b1;
    cycles = 0;
    // run high about three cycles in four
    while (halted !== 1'b1) begin
      run = (($random(seed) & 3) != 0);
      @(negedge clk);
      cycles++;
      if (cycles > haltTimeout) begin
        stopWithFailure($sformatf("core did not halt within %0d cycles", haltTimeout));
      end
    end
    // two younger slots drain after the stop
    run = 1'b1;
    repeat (4) @(negedge clk);
    if (traceIdx != traceEnd) begin
      stopWithFailure($sformatf("missing writeback, saw %0d of %0d expected",
                                traceIdx - traceStart[p], traceLen[p]));
    end
    checkFlag("halted", halted, 1'b1);
    checkFlag("illegal", illegal, expIllegal[p]);
    tracing = 1'b0;
    run = 1'b0;
  endtask

  initial begin
    seed = 32'hacf4_41fc;
    rstN = 1'b0;
    run = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    tracing = 1'b0;
    traceIdx = 0;
    traceEnd = 0;
    for (int p = 0; p < progCount; p++) begin
      runProgram(p);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

/* all.f */
+incdir+bench
rtl/rvPkg.sv
rtl/decodeIf.sv
rtl/instRom.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/cpu.sv
bench/cpuTb.sv
